/* logic/armPkg.sv */
package armPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 4;

    typedef logic [dataWidth-1:0]    word;
    typedef logic [regAddrWidth-1:0] regAddr;
    typedef logic [1:0]              aluOp;

    // Forwarding sources for the execute operands
    typedef enum logic [1:0] {
        fromRegister  = 2'b00,
        fromWriteback = 2'b01,
        fromMemory    = 2'b10
    } forwardSel;

    localparam regAddr pcReg = 4'd15;

    // Operation field, instr[27:26]
    localparam logic [1:0] dataProcOp = 2'b00;
    localparam logic [1:0] memoryOp   = 2'b01;
    localparam logic [1:0] branchOp   = 2'b10;

    // Command field, instr[24:21]
    localparam logic [3:0] cmdAnd = 4'b0000;
    localparam logic [3:0] cmdSub = 4'b0010;
    localparam logic [3:0] cmdAdd = 4'b0100;
    localparam logic [3:0] cmdOrr = 4'b1100;

    // ALU operations
    localparam aluOp aluAdd = 2'b00;
    localparam aluOp aluSub = 2'b01;
    localparam aluOp aluAnd = 2'b10;
    localparam aluOp aluOrr = 2'b11;

    // R15 reads see the fetch address plus 8
    localparam word pcReadOffset = 32'd8;

endpackage

/* logic/fetchStage.sv */
module fetchStage import armPkg::*; (
    input  logic CLK,
    input  logic reset,
    input  logic stallF,
    input  logic branchTaken,
    input  word  branchTarget,
    output word  pcF,
    output word  pcPlus8F
);

    word pcNext;

    // Branch redirect wins over stall; both never occur together
    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (stallF) begin
            pcNext = pcF;
        end else begin
            pcNext = pcF + 32'd4;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            pcF <= '0;
        end else begin
            pcF <= pcNext;
        end
    end

    assign pcPlus8F = pcF + pcReadOffset;

endmodule

/* logic/registerFile.sv */
module registerFile import armPkg::*; (
    input  logic   CLK,
    input  logic   reset,
    input  regAddr readAddr1,
    input  regAddr readAddr2,
    input  regAddr writeAddr,
    input  logic   writeEnable,
    input  word    writeData,
    input  word    pcPlus8,
    output word    readData1,
    output word    readData2
);

    word regs [0:14];

    // R15 comes from the PC; a same-cycle write is seen at once
    function automatic word readPort(regAddr addr);
        word value;
        if (addr == pcReg) begin
            value = pcPlus8;
        end else if (writeEnable && writeAddr == addr) begin
            value = writeData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != pcReg) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
    end

    noPcWrite: assert property (@(posedge CLK) disable iff (reset)
        writeEnable |-> writeAddr != pcReg)
        else $error("register file write to R15");

endmodule

/* logic/decodeStage.sv */
module decodeStage import armPkg::*; (
    input  logic   CLK,
    input  logic   reset,
    input  logic   stallD,
    input  logic   flushD,
    input  logic   flushE,
    input  word    instrF,
    input  word    pcPlus8F,
    input  word    readData1,
    input  word    readData2,
    output regAddr readAddr1,
    output regAddr readAddr2,
    output word    pcPlus8D,
    output word    operandAE,
    output word    operandBE,
    output word    immE,
    output regAddr srcRegAE,
    output regAddr srcRegBE,
    output regAddr destRegE,
    output aluOp   aluOpE,
    output logic   useImmE,
    output logic   regWriteE,
    output logic   memWriteE,
    output logic   memToRegE,
    output logic   branchE
);

    word        instrD;
    logic       validD;
    logic [1:0] opD;
    logic [3:0] cmdD;
    logic       cmdKnown;
    logic       isData;
    logic       isMem;
    logic       isBranch;
    aluOp       aluOpD;
    word        immD;

    //////////////////////////////////////////////////////////////////////
    // Fetch/decode register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset || flushD) begin
            validD <= 1'b0;
        end else if (!stallD) begin
            validD <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stallD) begin
            instrD   <= instrF;
            pcPlus8D <= pcPlus8F;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    assign opD  = instrD[27:26];
    assign cmdD = instrD[24:21];

    always_comb begin
        cmdKnown = 1'b1;
        case (cmdD)
            cmdAnd:  aluOpD = aluAnd;
            cmdSub:  aluOpD = aluSub;
            cmdOrr:  aluOpD = aluOrr;
            cmdAdd:  aluOpD = aluAdd;
            default: begin
                aluOpD   = aluAdd;
                cmdKnown = 1'b0;
            end
        endcase
        // Addresses and branch targets always add
        if (opD != dataProcOp) begin
            aluOpD = aluAdd;
        end
    end

    assign isData   = validD && opD == dataProcOp && cmdKnown;
    // Only immediate, positive offsets
    assign isMem    = validD && opD == memoryOp && !instrD[25] && instrD[23];
    assign isBranch = validD && opD == branchOp && instrD[25];

    always_comb begin
        if (isBranch) begin
            immD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
        end else if (isMem) begin
            immD = {20'd0, instrD[11:0]};
        end else begin
            immD = {24'd0, instrD[7:0]};
        end
    end

    // Branch reads R15 as its base; stores read Rd as data
    assign readAddr1 = isBranch ? pcReg : instrD[19:16];
    assign readAddr2 = isMem ? instrD[15:12] : instrD[3:0];

    //////////////////////////////////////////////////////////////////////
    // Decode/execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset || flushE) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            memToRegE <= 1'b0;
            branchE   <= 1'b0;
        end else begin
            regWriteE <= isData || (isMem && instrD[20]);
            memWriteE <= isMem && !instrD[20];
            memToRegE <= isMem && instrD[20];
            branchE   <= isBranch;
        end
    end

    always_ff @(posedge CLK) begin
        operandAE <= readData1;
        operandBE <= readData2;
        immE      <= immD;
        srcRegAE  <= readAddr1;
        srcRegBE  <= readAddr2;
        destRegE  <= instrD[15:12];
        aluOpE    <= aluOpD;
        useImmE   <= isMem || isBranch || (isData && instrD[25]);
    end

endmodule

/* logic/executeStage.sv */
module executeStage import armPkg::*; (
    input  logic      CLK,
    input  logic      reset,
    input  word       operandAE,
    input  word       operandBE,
    input  word       immE,
    input  regAddr    destRegE,
    input  aluOp      aluOpE,
    input  logic      useImmE,
    input  logic      regWriteE,
    input  logic      memWriteE,
    input  logic      memToRegE,
    input  logic      branchE,
    input  forwardSel forwardA,
    input  forwardSel forwardB,
    input  word       resultW,
    output logic      branchTaken,
    output word       branchTarget,
    output word       aluResultM,
    output word       storeDataM,
    output regAddr    destRegM,
    output logic      regWriteM,
    output logic      memWriteM,
    output logic      memToRegM
);

    word srcA;
    word srcB;
    word aluInB;
    word aluResultE;

    function automatic word forwardMux(forwardSel sel, word regValue, word wbValue,
                                       word memValue);
        word value;
        case (sel)
            fromWriteback: value = wbValue;
            fromMemory:    value = memValue;
            default:       value = regValue;
        endcase
        return value;
    endfunction

    always_comb begin
        srcA = forwardMux(forwardA, operandAE, resultW, aluResultM);
        srcB = forwardMux(forwardB, operandBE, resultW, aluResultM);
    end

    assign aluInB = useImmE ? immE : srcB;

    always_comb begin
        case (aluOpE)
            aluSub:  aluResultE = srcA - aluInB;
            aluAnd:  aluResultE = srcA & aluInB;
            aluOrr:  aluResultE = srcA | aluInB;
            default: aluResultE = srcA + aluInB;
        endcase
    end

    // Unconditional branches only, target is R15 plus offset
    assign branchTaken  = branchE;
    assign branchTarget = aluResultE;

    always_ff @(posedge CLK) begin
        if (reset) begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
            memToRegM <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
            memToRegM <= memToRegE;
        end
    end

    always_ff @(posedge CLK) begin
        aluResultM <= aluResultE;
        storeDataM <= srcB;
        destRegM   <= destRegE;
    end

    knownWrites: assert property (@(posedge CLK) disable iff (reset)
        !$isunknown({memWriteM, regWriteM}))
        else $error("memory stage write enables unknown");

endmodule

/* logic/writebackStage.sv */
module writebackStage import armPkg::*; (
    input  logic   CLK,
    input  logic   reset,
    input  word    aluResultM,
    input  word    readData,
    input  regAddr destRegM,
    input  logic   regWriteM,
    input  logic   memToRegM,
    output word    resultW,
    output regAddr writeRegW,
    output logic   regWriteW
);

    word  aluResultW;
    word  readDataW;
    logic memToRegW;

    always_ff @(posedge CLK) begin
        if (reset) begin
            regWriteW <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge CLK) begin
        aluResultW <= aluResultM;
        readDataW  <= readData;
        writeRegW  <= destRegM;
        memToRegW  <= memToRegM;
    end

    assign resultW = memToRegW ? readDataW : aluResultW;

endmodule

/* logic/hazardUnit.sv */
module hazardUnit import armPkg::*; (
    input  regAddr    srcRegAE,
    input  regAddr    srcRegBE,
    input  regAddr    srcRegAD,
    input  regAddr    srcRegBD,
    input  regAddr    destRegE,
    input  regAddr    destRegM,
    input  regAddr    writeRegW,
    input  logic      regWriteM,
    input  logic      regWriteW,
    input  logic      memToRegE,
    input  logic      memWriteM,
    input  logic      branchTaken,
    output forwardSel forwardA,
    output forwardSel forwardB,
    output logic      forwardStore,
    output logic      stallF,
    output logic      stallD,
    output logic      flushD,
    output logic      flushE
);

    logic loadUse;

    // Memory stage holds the younger result, so it wins
    function automatic forwardSel selectForward(regAddr src);
        forwardSel sel;
        if (regWriteM && destRegM == src) begin
            sel = fromMemory;
        end else if (regWriteW && writeRegW == src) begin
            sel = fromWriteback;
        end else begin
            sel = fromRegister;
        end
        return sel;
    endfunction

    always_comb begin
        forwardA = selectForward(srcRegAE);
        forwardB = selectForward(srcRegBE);
    end

    // For a store, destRegM names the data register
    assign forwardStore = memWriteM && regWriteW && writeRegW == destRegM;

    assign loadUse = memToRegE && (destRegE == srcRegAD || destRegE == srcRegBD);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushD = branchTaken;
    assign flushE = loadUse || branchTaken;

    // A load and a branch never share the execute stage
    always_comb begin
        noStallOnBranch: assert #0 (!(stallD && flushD))
            else $error("decode stalled during branch flush");
    end

endmodule

/* logic/armCore.sv */
module armCore import armPkg::*; (
    input  logic CLK,
    input  logic reset,
    input  word  instr,
    input  word  readData,
    output logic memWrite,
    output word  pc,
    output word  aluResult,
    output word  writeData
);

    //////////////////////////////////////////////////////////////////////
    // Stage wires
    //////////////////////////////////////////////////////////////////////

    word       pcPlus8F;
    word       pcPlus8D;
    regAddr    readAddr1;
    regAddr    readAddr2;
    word       readData1;
    word       readData2;

    word       operandAE;
    word       operandBE;
    word       immE;
    regAddr    srcRegAE;
    regAddr    srcRegBE;
    regAddr    destRegE;
    aluOp      aluOpE;
    logic      useImmE;
    logic      regWriteE;
    logic      memWriteE;
    logic      memToRegE;
    logic      branchE;

    logic      branchTaken;
    word       branchTarget;
    word       storeDataM;
    regAddr    destRegM;
    logic      regWriteM;
    logic      memToRegM;

    word       resultW;
    regAddr    writeRegW;
    logic      regWriteW;

    forwardSel forwardA;
    forwardSel forwardB;
    logic      forwardStore;
    logic      stallF;
    logic      stallD;
    logic      flushD;
    logic      flushE;

    // Store data may still be in flight to writeback
    assign writeData = forwardStore ? resultW : storeDataM;

    fetchStage fetch (
        .CLK          (CLK),
        .reset        (reset),
        .stallF       (stallF),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pcF          (pc),
        .pcPlus8F     (pcPlus8F)
    );

    decodeStage decode (
        .CLK       (CLK),
        .reset     (reset),
        .stallD    (stallD),
        .flushD    (flushD),
        .flushE    (flushE),
        .instrF    (instr),
        .pcPlus8F  (pcPlus8F),
        .readData1 (readData1),
        .readData2 (readData2),
        .readAddr1 (readAddr1),
        .readAddr2 (readAddr2),
        .pcPlus8D  (pcPlus8D),
        .operandAE (operandAE),
        .operandBE (operandBE),
        .immE      (immE),
        .srcRegAE  (srcRegAE),
        .srcRegBE  (srcRegBE),
        .destRegE  (destRegE),
        .aluOpE    (aluOpE),
        .useImmE   (useImmE),
        .regWriteE (regWriteE),
        .memWriteE (memWriteE),
        .memToRegE (memToRegE),
        .branchE   (branchE)
    );

    registerFile regFile (
        .CLK         (CLK),
        .reset       (reset),
        .readAddr1   (readAddr1),
        .readAddr2   (readAddr2),
        .writeAddr   (writeRegW),
        .writeEnable (regWriteW),
        .writeData   (resultW),
        .pcPlus8     (pcPlus8D),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    executeStage execute (
        .CLK          (CLK),
        .reset        (reset),
        .operandAE    (operandAE),
        .operandBE    (operandBE),
        .immE         (immE),
        .destRegE     (destRegE),
        .aluOpE       (aluOpE),
        .useImmE      (useImmE),
        .regWriteE    (regWriteE),
        .memWriteE    (memWriteE),
        .memToRegE    (memToRegE),
        .branchE      (branchE),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .resultW      (resultW),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .aluResultM   (aluResult),
        .storeDataM   (storeDataM),
        .destRegM     (destRegM),
        .regWriteM    (regWriteM),
        .memWriteM    (memWrite),
        .memToRegM    (memToRegM)
    );

    writebackStage writeback (
        .CLK        (CLK),
        .reset      (reset),
        .aluResultM (aluResult),
        .readData   (readData),
        .destRegM   (destRegM),
        .regWriteM  (regWriteM),
        .memToRegM  (memToRegM),
        .resultW    (resultW),
        .writeRegW  (writeRegW),
        .regWriteW  (regWriteW)
    );

    hazardUnit hazard (
        .srcRegAE     (srcRegAE),
        .srcRegBE     (srcRegBE),
        .srcRegAD     (readAddr1),
        .srcRegBD     (readAddr2),
        .destRegE     (destRegE),
        .destRegM     (destRegM),
        .writeRegW    (writeRegW),
        .regWriteM    (regWriteM),
        .regWriteW    (regWriteW),
        .memToRegE    (memToRegE),
        .memWriteM    (memWrite),
        .branchTaken  (branchTaken),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .forwardStore (forwardStore),
        .stallF       (stallF),
        .stallD       (stallD),
        .flushD       (flushD),
        .flushE       (flushE)
    );

endmodule

/* tests/storeChecker.sv */
module storeChecker import armPkg::*; #(
    parameter int maxStores    = 32,
    parameter int settleCycles = 20
) (
    input  logic CLK,
    input  logic reset,
    input  logic memWrite,
    input  word  pc,
    input  word  aluResult,
    input  word  writeData,
    input  word  expAddr [0:maxStores-1],
    input  word  expData [0:maxStores-1],
    input  int   expCount,
    output int   errorCount,
    output int   storeCount,
    output logic done
);

    localparam int indexWidth = $clog2(maxStores);

    int   errors      = 0;
    int   stores      = 0;
    int   settleCount = 0;
    logic finished    = 1'b0;
    logic pcChecked   = 1'b0;

    assign errorCount = errors;
    assign storeCount = stores;
    assign done       = finished;

    task automatic checkStore;
        $display("store %0d: address %h data %h", stores, aluResult, writeData);
        if (stores >= expCount) begin
            $display("unexpected store after all %0d expected stores, address %h",
                     expCount, aluResult);
            errors++;
        end else begin
            if (aluResult !== expAddr[indexWidth'(stores)]) begin
                $display("error: aluResult is %h, expected %h",
                         aluResult, expAddr[indexWidth'(stores)]);
                errors++;
            end
            if (writeData !== expData[indexWidth'(stores)]) begin
                $display("error: writeData is %h, expected %h",
                         writeData, expData[indexWidth'(stores)]);
                errors++;
            end
        end
        stores++;
    endtask

    // Ports are stable at the falling edge
    always @(negedge CLK) begin
        if (!reset) begin
            if (!pcChecked) begin
                pcChecked = 1'b1;
                if (pc !== 32'd0) begin
                    $display("error: pc after reset is %h, expected %h", pc, 32'd0);
                    errors++;
                end
            end
            if ($isunknown(memWrite)) begin
                $display("memWrite is unknown after reset");
                errors++;
            end else if (memWrite) begin
                checkStore();
            end
            // A few idle cycles catch late stray stores
            if (stores >= expCount && !finished) begin
                settleCount++;
                finished = settleCount >= settleCycles;
            end
        end
    end

endmodule

/* tests/armCoreTb.sv */
module armCoreTb import armPkg::*; ();

    localparam int clockPeriod = 8;
    localparam int resetLength = 8;
    localparam int stimWords   = 256;
    localparam int maxStores   = 32;
    localparam int dataWords   = 64;

    logic CLK   = 1'b0;
    logic reset = 1'b1;
    word  instr;
    word  readData;
    logic memWrite;
    word  pc;
    word  aluResult;
    word  writeData;

    word  stimMem [0:stimWords-1];
    word  dataMem [0:dataWords-1];
    word  expAddr [0:maxStores-1];
    word  expData [0:maxStores-1];
    word  progCount;
    word  storeBase;
    int   expCount;
    int   resetCycles = 0;

    int   errorCount;
    int   storeCount;
    logic done;

    always #(clockPeriod / 2) CLK = ~CLK;

    always @(posedge CLK) begin
        if (reset) begin
            resetCycles <= resetCycles + 1;
            if (resetCycles == resetLength - 1) begin
                reset <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    // Program follows the count word; zero beyond it is AND R0, R0, R0
    assign instr = ((pc >> 2) < progCount) ? stimMem[8'((pc >> 2) + 32'd1)] : 32'd0;

    assign readData = dataMem[aluResult[7:2]];

    always @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < dataWords; i++) begin
                dataMem[6'(i)] <= '0;
            end
        end else if (memWrite) begin
            dataMem[aluResult[7:2]] <= writeData;
        end
    end

    armCore uut (
        .CLK       (CLK),
        .reset     (reset),
        .instr     (instr),
        .readData  (readData),
        .memWrite  (memWrite),
        .pc        (pc),
        .aluResult (aluResult),
        .writeData (writeData)
    );

    storeChecker #(
        .maxStores (maxStores)
    ) storeCheck (
        .CLK        (CLK),
        .reset      (reset),
        .memWrite   (memWrite),
        .pc         (pc),
        .aluResult  (aluResult),
        .writeData  (writeData),
        .expAddr    (expAddr),
        .expData    (expData),
        .expCount   (expCount),
        .errorCount (errorCount),
        .storeCount (storeCount),
        .done       (done)
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus, run control and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        $readmemh("tests/programStim.mem", stimMem);
        progCount = stimMem[0];
        storeBase = progCount + 32'd1;
        expCount  = int'(stimMem[8'(storeBase)]);
        // Address/data pairs follow the store count
        for (int i = 0; i < maxStores; i++) begin
            expAddr[5'(i)] = stimMem[8'(storeBase + 32'd1 + 2 * i)];
            expData[5'(i)] = stimMem[8'(storeBase + 32'd2 + 2 * i)];
        end
        wait (done);
        $display("Run summary: %0d of %0d stores seen, %0d errors",
                 storeCount, expCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        word cycleLimit;
        @(posedge CLK);
        cycleLimit = 32'd20 * progCount + 32'd100;
        repeat (cycleLimit) @(posedge CLK);
        $display("The run timed out after %0d cycles before all expected stores were seen",
                 cycleLimit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* tests/programStim.mem */
// Word 0: program length, then the program words
// Then: expected store count, then one address/data pair per line
00000020
E280103C E28120F0  // ADD R1, R0, #3C    ADD R2, R1, #F0
E0423001 E0034002  // SUB R3, R2, R1     AND R4, R3, R2
E384500F E1856003  // ORR R5, R4, #0F    ORR R6, R5, R3
E2467010 E207803C  // SUB R7, R6, #10    AND R8, R7, #3C
E2809080 E5891000  // ADD R9, R0, #80    STR R1, [R9, #00]
E5892004 E5893008  // STR R2, [R9, #04]  STR R3, [R9, #08]
E589400C E5895010  // STR R4, [R9, #0C]  STR R5, [R9, #10]
E5896014 E5897018  // STR R6, [R9, #14]  STR R7, [R9, #18]
E589801C E288A011  // STR R8, [R9, #1C]  ADD R10, R8, #11
E589A020 E599B004  // STR R10, [R9, #20] LDR R11, [R9, #04]
E08BC001 E589C024  // ADD R12, R11, R1   STR R12, [R9, #24]
E599D008 E589D028  // LDR R13, [R9, #08] STR R13, [R9, #28]
E589F02C EA000001  // STR R15, [R9, #2C] B 70
E5891030 E5891034  // STR R1, [R9, #30]  STR R1, [R9, #34]  (skipped)
E286E001 E589E038  // ADD R14, R6, #01   STR R14, [R9, #38]
E589F03C EAFFFFFE  // STR R15, [R9, #3C] B 7C
0000000E
00000080 0000003C
00000084 0000012C
00000088 000000F0
0000008C 00000020
00000090 0000002F
00000094 000000FF
00000098 000000EF
0000009C 0000002C
000000A0 0000003D
000000A4 00000168
000000A8 000000F0
000000AC 00000068
000000B8 00000100
000000BC 00000080

/* files.f */
logic/armPkg.sv
logic/fetchStage.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/hazardUnit.sv
logic/armCore.sv
tests/storeChecker.sv
tests/armCoreTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = armCoreTb
FILELIST  = files.f
BUILD_DIR = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(BUILD_DIR)
